// ==== src/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // Four-way cache geometry
    localparam int NUM_WAYS  = 4;
    localparam int WAY_W     = 2;
    localparam int OFFSET_W  = 4;
    localparam int WORD_W    = 32;
    localparam int NUM_BANKS = 4;
    localparam int LINE_W    = 128;
    localparam int ADDR_W    = 32;

    typedef logic [WAY_W-1:0] way_t;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REPLACE,
        REFILL,
        UREQ,
        URESP
    } cache_state_e;

    // Result source for the CPU read data
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_HIT,
        SRC_REFILL,
        SRC_UNCACHED
    } rdata_src_e;

endpackage

`default_nettype wire

// ==== src/icache_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_fsm import icache_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       valid,
    input  logic       uncache,
    input  logic       cache_hit,
    input  logic       rd_rdy,
    input  logic       ret_valid,
    output logic       addr_ok,
    output logic       data_ok,
    output logic       rd_req,
    output logic       rd_type,
    output logic       lookup_rd,
    output logic       lookup_hit,
    output logic       lookup_miss,
    output logic       replace_touch,
    output logic       fill_en,
    output rdata_src_e rdata_src
);

    cache_state_e state;
    cache_state_e next_state;
    logic         uresp_done;

    // New requests only in IDLE or behind a hit
    assign addr_ok = valid && (state == IDLE || (state == LOOKUP && cache_hit));

    assign lookup_rd     = valid && addr_ok && !uncache;
    assign lookup_hit    = (state == LOOKUP) && cache_hit;
    assign lookup_miss   = (state == LOOKUP) && !cache_hit;
    assign replace_touch = (state == REPLACE);
    assign fill_en       = (state == REFILL) && ret_valid;
    assign uresp_done    = (state == URESP) && ret_valid;

    assign data_ok = lookup_hit || fill_en || uresp_done;

    // Line read from REPLACE, word read from UREQ
    assign rd_req  = (state == REPLACE) || (state == UREQ);
    assign rd_type = (state == REPLACE);

    always_comb begin
        if (lookup_hit) begin
            rdata_src = SRC_HIT;
        end else if (fill_en) begin
            rdata_src = SRC_REFILL;
        end else if (uresp_done) begin
            rdata_src = SRC_UNCACHED;
        end else begin
            rdata_src = SRC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (valid && addr_ok) begin
                    next_state = uncache ? UREQ : LOOKUP;
                end
            end
            LOOKUP: begin
                if (!cache_hit) begin
                    next_state = REPLACE;
                end else if (valid && addr_ok) begin
                    next_state = uncache ? UREQ : LOOKUP;
                end else begin
                    next_state = IDLE;
                end
            end
            REPLACE: begin
                if (rd_rdy) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    next_state = IDLE;
                end
            end
            UREQ: begin
                if (rd_rdy) begin
                    next_state = URESP;
                end
            end
            URESP: begin
                if (ret_valid) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/icache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array import icache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic                                 lookup_rd,
    input  logic [INDEX_W-1:0]                   index,
    input  logic                                 fill_en,
    input  way_t                                 fill_way,
    input  logic [INDEX_W-1:0]                   rb_index,
    input  logic [ADDR_W-INDEX_W-OFFSET_W-1:0]   rb_tag,
    output logic [NUM_WAYS-1:0]                  hit_vec,
    output logic                                 cache_hit
);

    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NUM_SETS = 1 << INDEX_W;

    logic [INDEX_W-1:0] ram_addr;

    // One RAM port shared by lookup and fill
    assign ram_addr = lookup_rd ? index : rb_index;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        logic [TAG_W-1:0]    tag_mem [NUM_SETS];
        logic [TAG_W-1:0]    tag_q;
        logic [NUM_SETS-1:0] valid_q;
        logic                way_we;

        assign way_we = fill_en && (fill_way == way_t'(w));

        always_ff @(posedge clk) begin
            if (way_we) begin
                tag_mem[ram_addr] <= rb_tag;
            end
            if (lookup_rd) begin
                tag_q <= tag_mem[ram_addr];
            end
        end

        always_ff @(posedge clk) begin
            if (!resetn) begin
                valid_q <= '0;
            end else if (way_we) begin
                valid_q[rb_index] <= 1'b1;
            end
        end

        // Compare in the cycle after the read
        assign hit_vec[w] = valid_q[rb_index] && (tag_q == rb_tag);
    end

    assign cache_hit = |hit_vec;

endmodule

`default_nettype wire

// ==== src/icache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_data_array import icache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  logic                clk,
    input  logic                lookup_rd,
    input  logic [INDEX_W-1:0]  index,
    input  logic                fill_en,
    input  way_t                fill_way,
    input  logic [INDEX_W-1:0]  rb_index,
    input  logic [LINE_W-1:0]   fill_line,
    input  logic [NUM_WAYS-1:0] hit_vec,
    output logic [LINE_W-1:0]   hit_line
);

    localparam int NUM_SETS = 1 << INDEX_W;

    logic [INDEX_W-1:0] ram_addr;
    logic [LINE_W-1:0]  way_line [NUM_WAYS];

    assign ram_addr = lookup_rd ? index : rb_index;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        logic [WORD_W-1:0] bank_mem [NUM_BANKS][NUM_SETS];
        logic [LINE_W-1:0] line_q;
        logic              bank_we;

        // Fills always write all four banks of the way
        assign bank_we = fill_en && (fill_way == way_t'(w));

        always_ff @(posedge clk) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (bank_we) begin
                    bank_mem[b][ram_addr] <= fill_line[b*WORD_W +: WORD_W];
                end
                if (lookup_rd) begin
                    line_q[b*WORD_W +: WORD_W] <= bank_mem[b][ram_addr];
                end
            end
        end

        assign way_line[w] = line_q;
    end

    // At most one way hits
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_line = hit_line | ({LINE_W{hit_vec[w]}} & way_line[w]);
        end
    end

endmodule

`default_nettype wire

// ==== src/icache_plru.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_plru import icache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic [INDEX_W-1:0]  rb_index,
    input  logic                lookup_hit,
    input  logic [NUM_WAYS-1:0] hit_vec,
    input  logic                lookup_miss,
    input  logic                replace_touch,
    output way_t                victim_way
);

    localparam int NUM_SETS = 1 << INDEX_W;

    logic [NUM_WAYS-1:0] mru_q [NUM_SETS];
    logic [NUM_WAYS-1:0] mru_cur;
    logic [NUM_WAYS-1:0] touch_mask;
    logic [NUM_WAYS-1:0] mru_set;
    logic [NUM_WAYS-1:0] mru_next;
    way_t                hit_way;
    way_t                touch_way;
    way_t                free_way;

    assign mru_cur = mru_q[rb_index];

    always_comb begin
        hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // Lowest way not recently used
    always_comb begin
        free_way = victim_way;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!mru_cur[w]) begin
                free_way = way_t'(w);
            end
        end
    end

    assign touch_way  = lookup_hit ? hit_way : victim_way;
    assign touch_mask = NUM_WAYS'(1) << touch_way;
    assign mru_set    = mru_cur | touch_mask;

    // Touching the last clear way starts over with only that bit set
    assign mru_next = (&mru_set) ? touch_mask : mru_set;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                mru_q[s] <= '0;
            end
            victim_way <= '0;
        end else begin
            if (lookup_hit || replace_touch) begin
                mru_q[rb_index] <= mru_next;
            end
            if (lookup_miss) begin
                victim_way <= free_way;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  logic                               clk,
    input  logic                               resetn,
    // CPU side
    input  logic                               valid,
    input  logic                               uncache,
    input  logic [ADDR_W-INDEX_W-OFFSET_W-1:0] tag,
    input  logic [INDEX_W-1:0]                 index,
    input  logic [OFFSET_W-1:0]                offset,
    output logic                               addr_ok,
    output logic                               data_ok,
    output logic [LINE_W-1:0]                  rdata,
    output logic [1:0]                         rnum,
    // Memory side
    output logic                               rd_req,
    output logic                               rd_type,
    output logic [ADDR_W-1:0]                  rd_addr,
    input  logic                               rd_rdy,
    input  logic                               ret_valid,
    input  logic [LINE_W-1:0]                  ret_data
);

    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    logic [TAG_W-1:0]    rb_tag;
    logic [INDEX_W-1:0]  rb_index;
    logic [OFFSET_W-1:0] rb_offset;
    logic [1:0]          word_off;

    logic                cache_hit;
    logic [NUM_WAYS-1:0] hit_vec;
    logic [LINE_W-1:0]   hit_line;
    logic [LINE_W-1:0]   src_line;
    way_t                victim_way;
    rdata_src_e          rdata_src;

    logic lookup_rd;
    logic lookup_hit;
    logic lookup_miss;
    logic replace_touch;
    logic fill_en;

    // Request buffer
    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            rb_tag    <= tag;
            rb_index  <= index;
            rb_offset <= offset;
        end
    end

    assign word_off = rb_offset[OFFSET_W-1:2];

    // Addressed word moves down to bits 31:0
    always_comb begin
        case (rdata_src)
            SRC_HIT:      src_line = hit_line >> (word_off * WORD_W);
            SRC_REFILL:   src_line = ret_data >> (word_off * WORD_W);
            SRC_UNCACHED: src_line = {{(LINE_W - WORD_W){1'b0}}, ret_data[WORD_W-1:0]};
            default:      src_line = '0;
        endcase
    end

    assign rdata = src_line;
    assign rnum  = (rdata_src == SRC_UNCACHED) ? 2'd0 : 2'(NUM_BANKS - 1) - word_off;

    // Line reads are aligned, word reads keep the byte offset
    assign rd_addr = rd_type ? {rb_tag, rb_index, {OFFSET_W{1'b0}}}
                             : {rb_tag, rb_index, rb_offset};

    icache_fsm u_fsm (
        .clk           (clk),
        .resetn        (resetn),
        .valid         (valid),
        .uncache       (uncache),
        .cache_hit     (cache_hit),
        .rd_rdy        (rd_rdy),
        .ret_valid     (ret_valid),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .rd_req        (rd_req),
        .rd_type       (rd_type),
        .lookup_rd     (lookup_rd),
        .lookup_hit    (lookup_hit),
        .lookup_miss   (lookup_miss),
        .replace_touch (replace_touch),
        .fill_en       (fill_en),
        .rdata_src     (rdata_src)
    );

    icache_tag_array #(
        .INDEX_W (INDEX_W)
    ) u_tag_array (
        .clk       (clk),
        .resetn    (resetn),
        .lookup_rd (lookup_rd),
        .index     (index),
        .fill_en   (fill_en),
        .fill_way  (victim_way),
        .rb_index  (rb_index),
        .rb_tag    (rb_tag),
        .hit_vec   (hit_vec),
        .cache_hit (cache_hit)
    );

    icache_data_array #(
        .INDEX_W (INDEX_W)
    ) u_data_array (
        .clk       (clk),
        .lookup_rd (lookup_rd),
        .index     (index),
        .fill_en   (fill_en),
        .fill_way  (victim_way),
        .rb_index  (rb_index),
        .fill_line (ret_data),
        .hit_vec   (hit_vec),
        .hit_line  (hit_line)
    );

    icache_plru #(
        .INDEX_W (INDEX_W)
    ) u_plru (
        .clk           (clk),
        .resetn        (resetn),
        .rb_index      (rb_index),
        .lookup_hit    (lookup_hit),
        .hit_vec       (hit_vec),
        .lookup_miss   (lookup_miss),
        .replace_touch (replace_touch),
        .victim_way    (victim_way)
    );

endmodule

`default_nettype wire

// ==== sim/icache_mem_responder.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_mem_responder import icache_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  logic              rd_req,
    input  logic              rd_type,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic              rd_rdy,
    output logic              ret_valid,
    output logic [LINE_W-1:0] ret_data
);

    localparam logic [WORD_W-1:0] MEM_OFS = 32'h1000_0000;

    integer            seed;
    logic              busy;
    int                stall;
    logic [ADDR_W-1:0] addr_q;
    logic              line_q;

    // Word reads fill the upper banks with junk the cache must drop
    function automatic logic [LINE_W-1:0] read_data(input logic is_line,
                                                    input logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] data;
        logic [WORD_W-1:0] word;
        if (is_line) begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                data[i*WORD_W +: WORD_W] = addr + 4 * i + MEM_OFS;
            end
        end else begin
            word = addr + MEM_OFS;
            data = {~word, ~word, ~word, word};
        end
        return data;
    endfunction

    initial begin
        seed      = 93;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        busy      = 1'b0;
        stall     = 0;
    end

    always @(posedge clk) begin
        if (!resetn) begin
            rd_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            busy      <= 1'b0;
            stall     <= 0;
        end else begin
            ret_valid <= 1'b0;
            if (busy) begin
                if (stall == 0) begin
                    ret_valid <= 1'b1;
                    ret_data  <= read_data(line_q, addr_q);
                    busy      <= 1'b0;
                    stall     <= $unsigned($random(seed)) % 4;
                end else begin
                    stall <= stall - 1;
                end
            end else if (rd_req && rd_rdy) begin
                rd_rdy <= 1'b0;
                busy   <= 1'b1;
                addr_q <= rd_addr;
                line_q <= rd_type;
                stall  <= $unsigned($random(seed)) % 4;
            end else if (rd_req) begin
                if (stall == 0) begin
                    rd_rdy <= 1'b1;
                end else begin
                    stall <= stall - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tb import icache_pkg::*; ();

    localparam int INDEX_W         = 8;
    localparam int TAG_W           = ADDR_W - INDEX_W - OFFSET_W;
    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 5;
    localparam int CYCLES_PER_CASE = 40;
    localparam logic [WORD_W-1:0] MEM_OFS = 32'h1000_0000;

    logic                clk;
    logic                resetn;
    logic                valid;
    logic                uncache;
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
    logic                addr_ok;
    logic                data_ok;
    logic [LINE_W-1:0]   rdata;
    logic [1:0]          rnum;
    logic                rd_req;
    logic                rd_type;
    logic [ADDR_W-1:0]   rd_addr;
    logic                rd_rdy;
    logic                ret_valid;
    logic [LINE_W-1:0]   ret_data;

    logic              case_unc  [$];
    logic [ADDR_W-1:0] case_addr [$];
    logic              case_miss [$];
    int                pend_q    [$];
    int                acc_cycle [];
    bit                miss_seen [];
    int                cycle        = 0;
    int                done_count   = 0;
    bit                cases_loaded = 0;

    icache_top #(
        .INDEX_W (INDEX_W)
    ) UUT (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .uncache   (uncache),
        .tag       (tag),
        .index     (index),
        .offset    (offset),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rnum      (rnum),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    icache_mem_responder u_mem (
        .clk       (clk),
        .resetn    (resetn),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [LINE_W-1:0] expected,
                               input logic [LINE_W-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            abort_run("value mismatch");
        end
    endtask

    function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        return addr + MEM_OFS;
    endfunction

    // Words from the addressed one upward, zeros past the end of the line
    function automatic logic [LINE_W-1:0] expect_rdata(input logic unc,
                                                       input logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] line;
        logic [ADDR_W-1:0] base;
        int                off;
        line = '0;
        base = {addr[ADDR_W-1:2], 2'b00};
        off  = addr[3:2];
        if (unc) begin
            line[WORD_W-1:0] = mem_word(addr);
        end else begin
            for (int i = 0; i < NUM_BANKS - off; i++) begin
                line[i*WORD_W +: WORD_W] = mem_word(base + 4 * i);
            end
        end
        return line;
    endfunction

    task automatic load_cases();
        int                fd;
        int                got;
        int                n;
        int                u;
        int                m;
        logic [ADDR_W-1:0] a;
        string             line;
        fd = $fopen("sim/icache_cases.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the case file sim/icache_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                got  = $fgets(line, fd);
                if (got > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %h %d", u, a, m);
                    if (n == 3) begin
                        case_unc.push_back(u[0]);
                        case_addr.push_back(a);
                        case_miss.push_back(m[0]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Any memory read belongs to the oldest outstanding request
    task automatic check_mem_request();
        int                idx;
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] exp_addr;
        if (pend_q.size() == 0) begin
            abort_run("Memory read issued while no request was outstanding");
        end else begin
            idx  = pend_q[0];
            addr = case_addr[idx];
            exp_addr = case_unc[idx] ? addr : {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
            miss_seen[idx] = 1'b1;
            check_value($sformatf("case %0d rd_type", idx), !case_unc[idx], rd_type);
            check_value($sformatf("case %0d rd_addr", idx), exp_addr, rd_addr);
        end
    endtask

    task automatic check_response();
        int                idx;
        logic              unc;
        logic [ADDR_W-1:0] addr;
        if (pend_q.size() == 0) begin
            abort_run("data_ok pulsed while no request was outstanding");
        end else begin
            idx  = pend_q.pop_front();
            unc  = case_unc[idx];
            addr = case_addr[idx];
            check_value($sformatf("case %0d rdata", idx), expect_rdata(unc, addr), rdata);
            check_value($sformatf("case %0d rnum", idx), unc ? 2'd0 : 2'd3 - addr[3:2], rnum);
            check_value($sformatf("case %0d miss", idx), case_miss[idx], miss_seen[idx]);
            if (!case_miss[idx]) begin
                check_value($sformatf("case %0d hit latency", idx), acc_cycle[idx] + 1, cycle);
            end
            done_count++;
        end
    endtask

    always @(posedge clk) begin
        if (resetn) begin
            if (rd_req && rd_rdy) begin
                check_mem_request();
            end
            if (data_ok) begin
                check_response();
            end
        end
    end

    initial begin : drive
        logic [ADDR_W-1:0] addr;
        resetn  = 1'b0;
        valid   = 1'b0;
        uncache = 1'b0;
        tag     = '0;
        index   = '0;
        offset  = '0;
        load_cases();
        acc_cycle    = new[case_addr.size()];
        miss_seen    = new[case_addr.size()];
        cases_loaded = 1'b1;
        if (case_addr.size() == 0) begin
            abort_run("The case file holds no accesses");
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            resetn <= 1'b1;
            @(posedge clk);
            for (int i = 0; i < case_addr.size(); i++) begin
                addr = case_addr[i];
                valid   <= 1'b1;
                uncache <= case_unc[i];
                tag     <= addr[ADDR_W-1:INDEX_W+OFFSET_W];
                index   <= addr[INDEX_W+OFFSET_W-1:OFFSET_W];
                offset  <= addr[OFFSET_W-1:0];
                @(posedge clk);
                while (!addr_ok) @(posedge clk);
                acc_cycle[i] = cycle;
                pend_q.push_back(i);
                // A hit frees the port in its LOOKUP cycle
                if (i > 0 && !case_unc[i-1] && !case_miss[i-1]) begin
                    check_value($sformatf("case %0d accept cycle", i),
                                acc_cycle[i-1] + 1, acc_cycle[i]);
                end
            end
            valid <= 1'b0;
            wait (done_count == case_addr.size());
            $display("Regression passed");
            $finish;
        end
    end

    initial begin : watchdog
        cache_state_e fsm_state;
        wait (cases_loaded);
        #((case_addr.size() * CYCLES_PER_CASE + RESET_CYCLES + 1) * CLK_PERIOD);
        fsm_state = UUT.u_fsm.state;
        abort_run($sformatf("Run timed out with %0d of %0d responses, controller in %s",
                            done_count, case_addr.size(), fsm_state.name()));
    end

endmodule

`default_nettype wire

// ==== sim/icache_cases.txt ====
# uncache address expect_miss, address in hex
# expect_miss is 1 when the access must read memory
0 00001000 1
0 00001008 0
0 0000100c 0
0 00001006 0
1 00002010 1
0 00002010 1
0 00002014 0
0 00010050 1
0 00011054 1
0 00012058 1
0 0001305c 1
0 00014050 1
0 00010050 1
0 00014058 0
0 00001004 0
1 00003008 1
0 0000201c 0
0 00002018 0

// ==== filelist.f ====
src/icache_pkg.sv
src/icache_fsm.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_plru.sv
src/icache_top.sv
sim/icache_mem_responder.sv
sim/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - src/icache_pkg.sv
  - src/icache_fsm.sv
  - src/icache_tag_array.sv
  - src/icache_data_array.sv
  - src/icache_plru.sv
  - src/icache_top.sv
  - target: simulation
    files:
      - sim/icache_mem_responder.sv
      - sim/icache_tb.sv
